/* source/cache_geom_pkg.sv */
package cache_geom_pkg;

    // cache shape, direct mapped
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int NUM_LINES       = 8;

    // processor word address split
    localparam int TAG_W        = 25;
    localparam int INDEX_W      = 3;
    localparam int OFFSET_W     = 2;
    localparam int BLOCK_ADDR_W = TAG_W + INDEX_W;    // memory works in blocks

    localparam int BLOCK_W = WORDS_PER_BLOCK * WORD_W;

    // 30-bit word address as the processor sends it
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } proc_addr_t;

    // one block, seen flat on the memory port or as words inside the cache
    // words[k] sits at bits 32k+31 down to 32k
    typedef union packed {
        logic [BLOCK_W-1:0]                          bits;
        logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0]      words;
    } block_u;

endpackage

/* source/cache_bus_pkg.sv */
package cache_bus_pkg;

    // processor side request, held until stall is seen low
    typedef struct packed {
        logic                               read;
        logic                               write;
        cache_geom_pkg::proc_addr_t         addr;
        logic [cache_geom_pkg::WORD_W-1:0]  wdata;
    } proc_req_t;

    // memory side request, one whole block per transfer
    typedef struct packed {
        logic                                     read;
        logic                                     write;
        logic [cache_geom_pkg::BLOCK_ADDR_W-1:0]  addr;    // block address
        cache_geom_pkg::block_u                   wdata;
    } mem_req_t;

    // controller states
    // READ_FILL      fetching a block for a read miss
    // WRITE_FILL     fetching a block for a write miss
    // WRITE_THROUGH  block write to memory in flight
    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        READ_FILL     = 2'd1,
        WRITE_FILL    = 2'd2,
        WRITE_THROUGH = 2'd3
    } ctrl_state_e;

endpackage

/* source/cache_tag_store.sv */
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  cache_geom_pkg::proc_addr_t addr,
    input  logic                       tag_we,
    output logic                       hit
);

    logic [cache_geom_pkg::NUM_LINES-1:0] valid;
    logic [cache_geom_pkg::TAG_W-1:0]     tags [cache_geom_pkg::NUM_LINES];

    logic [cache_geom_pkg::TAG_W-1:0]     stored_tag;    // tag of the indexed line

    assign stored_tag = tags[addr.index];

    // same-cycle lookup with no output register
    assign hit = valid[addr.index] && (stored_tag == addr.tag);

    // valid bits cleared on reset
    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid <= '0;
        end
        else if (tag_we)
        begin
            valid[addr.index] <= 1'b1;
        end
    end

    // tag of the indexed line written on each fill
    always_ff @(posedge clk)
    begin
        if (tag_we)
        begin
            tags[addr.index] <= addr.tag;
        end
    end

endmodule

/* source/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store (
    input  logic                              clk,
    input  cache_geom_pkg::proc_addr_t        addr,
    input  logic [cache_geom_pkg::WORD_W-1:0] wdata,
    input  logic                              fill_we,
    input  cache_geom_pkg::block_u            fill_block,
    input  logic                              word_we,
    output cache_geom_pkg::block_u            line_block,
    output logic [cache_geom_pkg::WORD_W-1:0] rdata
);

    cache_geom_pkg::block_u lines [cache_geom_pkg::NUM_LINES];

    cache_geom_pkg::block_u rd_block;    // block the read word is taken from

    assign line_block = lines[addr.index];

    // during a fill the word comes straight from the incoming block,
    // so a read miss is answered in the mem_ready cycle
    always_comb
    begin
        if (fill_we)
        begin
            rd_block = fill_block;
        end
        else
        begin
            rd_block = line_block;
        end
    end

    assign rdata = rd_block.words[addr.offset];

    // whole block on a fill, else a single word on a write hit
    always_ff @(posedge clk)
    begin
        if (fill_we)
        begin
            lines[addr.index] <= fill_block;
        end
        else if (word_we)
        begin
            lines[addr.index].words[addr.offset] <= wdata;
        end
    end

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
    input  logic                     clk,
    input  logic                     proc_reset,
    input  cache_bus_pkg::proc_req_t proc_req,
    input  logic                     hit,
    input  cache_geom_pkg::block_u   line_block,
    input  cache_geom_pkg::block_u   mem_rdata,
    input  logic                     mem_ready,
    output logic                     tag_we,
    output logic                     fill_we,
    output logic                     word_we,
    output cache_geom_pkg::block_u   fill_block,
    output logic                     proc_stall,
    output cache_bus_pkg::mem_req_t  mem_req
);

    cache_bus_pkg::ctrl_state_e state;
    cache_bus_pkg::ctrl_state_e state_nxt;
    cache_bus_pkg::mem_req_t    mem_req_nxt;

    cache_geom_pkg::block_u                  merged;      // block with the proc word in
    logic [cache_geom_pkg::BLOCK_ADDR_W-1:0] blk_addr;

    assign blk_addr = {proc_req.addr.tag, proc_req.addr.index};

    // write miss merges into the fetched block, write hit into the stored line
    always_comb
    begin
        if (state == cache_bus_pkg::WRITE_FILL)
        begin
            merged = mem_rdata;
        end
        else
        begin
            merged = line_block;
        end
        merged.words[proc_req.addr.offset] = proc_req.wdata;
    end

    // line content on a fill is exactly what goes out on the write-through
    assign fill_block = (state == cache_bus_pkg::WRITE_FILL) ? merged : mem_rdata;

    // tag and valid are written with every fill
    assign tag_we = fill_we;

    // stall and store enables, all combinational
    always_comb
    begin
        proc_stall = 1'b0;
        fill_we    = 1'b0;
        word_we    = 1'b0;
        case (state)
            cache_bus_pkg::IDLE:
            begin
                if (proc_req.read)
                begin
                    proc_stall = !hit;    // read hit answers this cycle
                end
                else if (proc_req.write)
                begin
                    proc_stall = 1'b1;    // every write waits for memory
                    word_we    = hit;
                end
            end
            cache_bus_pkg::READ_FILL:
            begin
                proc_stall = !mem_ready;
                fill_we    = mem_ready;
            end
            cache_bus_pkg::WRITE_FILL:
            begin
                proc_stall = 1'b1;        // write-through still to come
                fill_we    = mem_ready;
            end
            cache_bus_pkg::WRITE_THROUGH:
            begin
                proc_stall = !mem_ready;
            end
            default:
            begin
                proc_stall = 1'b0;
            end
        endcase
    end

    // next state and next memory request
    always_comb
    begin
        state_nxt   = state;
        mem_req_nxt = mem_req;
        case (state)
            cache_bus_pkg::IDLE:
            begin
                if (proc_req.read && !hit)
                begin
                    state_nxt        = cache_bus_pkg::READ_FILL;
                    mem_req_nxt.read = 1'b1;
                    mem_req_nxt.addr = blk_addr;
                end
                else if (proc_req.write)
                begin
                    mem_req_nxt.addr = blk_addr;
                    if (hit)
                    begin
                        state_nxt         = cache_bus_pkg::WRITE_THROUGH;
                        mem_req_nxt.write = 1'b1;
                        mem_req_nxt.wdata = merged;
                    end
                    else
                    begin
                        state_nxt        = cache_bus_pkg::WRITE_FILL;
                        mem_req_nxt.read = 1'b1;    // allocate first
                    end
                end
            end
            cache_bus_pkg::READ_FILL:
            begin
                if (mem_ready)
                begin
                    state_nxt        = cache_bus_pkg::IDLE;
                    mem_req_nxt.read = 1'b0;
                end
            end
            cache_bus_pkg::WRITE_FILL:
            begin
                if (mem_ready)
                begin
                    // turn the fetch straight into the block write, same address
                    state_nxt         = cache_bus_pkg::WRITE_THROUGH;
                    mem_req_nxt.read  = 1'b0;
                    mem_req_nxt.write = 1'b1;
                    mem_req_nxt.wdata = merged;
                end
            end
            cache_bus_pkg::WRITE_THROUGH:
            begin
                if (mem_ready)
                begin
                    state_nxt         = cache_bus_pkg::IDLE;
                    mem_req_nxt.write = 1'b0;
                end
            end
            default:
            begin
                state_nxt = cache_bus_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state   <= cache_bus_pkg::IDLE;
            mem_req <= '0;                  // flags, address and data all zero
        end
        else
        begin
            state   <= state_nxt;
            mem_req <= mem_req_nxt;
        end
    end

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  cache_bus_pkg::proc_req_t          proc_req,
    output logic [cache_geom_pkg::WORD_W-1:0] proc_rdata,
    output logic                              proc_stall,
    output cache_bus_pkg::mem_req_t           mem_req,
    input  cache_geom_pkg::block_u            mem_rdata,
    input  logic                              mem_ready
);

    logic                   hit;
    logic                   tag_we;
    logic                   fill_we;
    logic                   word_we;
    cache_geom_pkg::block_u fill_block;
    cache_geom_pkg::block_u line_block;    // indexed line, for write-through merge

    cache_tag_store u_tag_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (proc_req.addr),
        .tag_we     (tag_we),
        .hit        (hit)
    );

    cache_data_store u_data_store (
        .clk        (clk),
        .addr       (proc_req.addr),
        .wdata      (proc_req.wdata),
        .fill_we    (fill_we),
        .fill_block (fill_block),
        .word_we    (word_we),
        .line_block (line_block),
        .rdata      (proc_rdata)
    );

    cache_controller u_controller (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .hit        (hit),
        .line_block (line_block),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .tag_we     (tag_we),
        .fill_we    (fill_we),
        .word_we    (word_we),
        .fill_block (fill_block),
        .proc_stall (proc_stall),
        .mem_req    (mem_req)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic proc_reset
);

    localparam int HALF_NS = 20;    // 40 ns period

    initial
    begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // reset held over the first three rising edges, released on a falling edge
    initial
    begin
        proc_reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;
    end

endmodule

/* testbench/cache_asserts.sv */
`timescale 1ns/1ps

module cache_asserts (
    input logic                    clk,
    input logic                    proc_reset,
    input cache_bus_pkg::mem_req_t mem_req,
    input logic                    mem_ready
);

    // one block transfer at a time
    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_req.read && mem_req.write)
    ) else $error("mem_req has read and write high together");

    // a waiting request must not move until memory answers
    a_req_held: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) && !mem_ready
        |=> $stable(mem_req.read) && $stable(mem_req.write)
            && $stable(mem_req.addr) && $stable(mem_req.wdata)
    ) else $error("mem_req changed while waiting for mem_ready");

    a_idle_after_reset: assert property (
        @(posedge clk) $fell(proc_reset) |-> !mem_req.read && !mem_req.write
    ) else $error("mem_req not idle right after reset");

endmodule

bind cache_controller cache_asserts asserts0 (
    .clk        (clk),
    .proc_reset (proc_reset),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready)
);

/* testbench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int     CLK_NS   = 40;
    localparam int     RAND_OPS = 400;
    localparam longint WATCH_NS = longint'(RAND_OPS + 40) * 8 * CLK_NS * 2;    // 2x margin

    logic                              clk;
    logic                              proc_reset;
    cache_bus_pkg::proc_req_t          proc_req;
    logic [cache_geom_pkg::WORD_W-1:0] proc_rdata;
    logic                              proc_stall;
    cache_bus_pkg::mem_req_t           mem_req;
    cache_geom_pkg::block_u            mem_rdata;
    logic                              mem_ready;

    integer seed = 32'h7997_0f4c;
    int     err_count = 0;
    int     check_count = 0;
    int     test_count = 0;
    int     test_errs = 0;    // error count when the current test began

    // reference model of the word image plus tag table
    logic [cache_geom_pkg::WORD_W-1:0] ref_words [logic [29:0]];
    logic                              model_valid [cache_geom_pkg::NUM_LINES];
    logic [cache_geom_pkg::TAG_W-1:0]  model_tag [cache_geom_pkg::NUM_LINES];
    // memory model holds only what the DUT wrote back
    cache_geom_pkg::block_u mem_blocks [logic [cache_geom_pkg::BLOCK_ADDR_W-1:0]];

    tb_clock_gen clk_gen0 (
        .clk        (clk),
        .proc_reset (proc_reset)
    );

    cache_top dut0 (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    // unwritten memory pattern from the full word address
    function automatic logic [31:0] fill_word(input logic [29:0] waddr);
        return {waddr, 2'b10};
    endfunction

    function automatic logic [31:0] ref_word(input logic [29:0] waddr);
        if (ref_words.exists(waddr))
            return ref_words[waddr];
        return fill_word(waddr);
    endfunction

    function automatic cache_geom_pkg::block_u ref_block(input logic [27:0] blk);
        cache_geom_pkg::block_u b;
        for (int k = 0; k < cache_geom_pkg::WORDS_PER_BLOCK; k++)
            b.words[k] = ref_word({blk, 2'(k)});
        return b;
    endfunction

    function automatic cache_geom_pkg::block_u mem_block(input logic [27:0] blk);
        cache_geom_pkg::block_u b;
        if (mem_blocks.exists(blk))
            return mem_blocks[blk];
        for (int k = 0; k < cache_geom_pkg::WORDS_PER_BLOCK; k++)
            b.words[k] = fill_word({blk, 2'(k)});
        return b;
    endfunction

    function automatic cache_geom_pkg::proc_addr_t make_addr(input logic [24:0] tag,
                                                             input logic [2:0] index,
                                                             input logic [1:0] offset);
        cache_geom_pkg::proc_addr_t a;
        a.tag    = tag;
        a.index  = index;
        a.offset = offset;
        return a;
    endfunction

    function automatic logic model_hit(input cache_geom_pkg::proc_addr_t a);
        return model_valid[a.index] && (model_tag[a.index] == a.tag);
    endfunction

    task automatic check_word(input string name, input logic [cache_geom_pkg::WORD_W-1:0] got,
                              input logic [cache_geom_pkg::WORD_W-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED time %0t %s seen %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input cache_geom_pkg::block_u got,
                               input cache_geom_pkg::block_u exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED time %0t %s seen %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [cache_geom_pkg::BLOCK_ADDR_W-1:0] got,
                              input logic [cache_geom_pkg::BLOCK_ADDR_W-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED time %0t %s seen %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED time %0t %s seen %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic note_error(input string what);
        err_count++;
        $display("time %0t: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_errs)
            $display("test %0d %s: ok", test_count, name);
        else
            $display("test %0d %s: %0d errors", test_count, name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic do_read(input cache_geom_pkg::proc_addr_t a);
        logic        exp_hit;
        logic [31:0] exp_word;
        int          cycles;
        exp_hit  = model_hit(a);
        exp_word = ref_word(a);
        @(negedge clk);
        proc_req.read  = 1'b1;
        proc_req.write = 1'b0;
        proc_req.addr  = a;
        proc_req.wdata = '0;
        #5;
        check_bit("proc_stall", proc_stall, !exp_hit);    // hit or miss shows in the same cycle
        cycles = 0;
        while (proc_stall && cycles < 20)
        begin
            @(negedge clk);
            #5;
            cycles++;
            if (cycles == 1)
                check_bit("mem_req.read", mem_req.read, 1'b1);
        end
        if (proc_stall)
            note_error("read request was never completed by the cache");
        check_word("proc_rdata", proc_rdata, exp_word);
        model_valid[a.index] = 1'b1;
        model_tag[a.index]   = a.tag;
        @(negedge clk);
        proc_req = '0;
    endtask

    task automatic do_write(input cache_geom_pkg::proc_addr_t a, input logic [31:0] d);
        logic                   exp_hit;
        logic                   saw_read;
        logic                   saw_write;
        cache_geom_pkg::block_u exp_blk;
        int                     cycles;
        exp_hit = model_hit(a);
        exp_blk = ref_block({a.tag, a.index});
        exp_blk.words[a.offset] = d;
        @(negedge clk);
        proc_req.read  = 1'b0;
        proc_req.write = 1'b1;
        proc_req.addr  = a;
        proc_req.wdata = d;
        #5;
        check_bit("proc_stall", proc_stall, 1'b1);
        saw_read  = 1'b0;
        saw_write = 1'b0;
        cycles    = 0;
        while (proc_stall && cycles < 20)
        begin
            @(negedge clk);
            #5;
            cycles++;
            if (mem_req.read)
                saw_read = 1'b1;
            if (mem_req.write && !saw_write)
            begin
                saw_write = 1'b1;    // first cycle of the write-through
                check_bit("block fetch before write", saw_read, !exp_hit);
                check_block("mem_req.wdata", mem_req.wdata, exp_blk);
                check_addr("mem_req.addr", mem_req.addr, {a.tag, a.index});
            end
        end
        if (proc_stall)
            note_error("write request was never completed by the cache");
        check_bit("write-through issued", saw_write, 1'b1);
        ref_words[a]         = d;
        model_valid[a.index] = 1'b1;    // write-allocate
        model_tag[a.index]   = a.tag;
        @(negedge clk);
        proc_req = '0;
    endtask

    // memory model answers after 1 to 4 cycles with a one-cycle mem_ready
    initial
    begin
        int delay_left;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        delay_left = -1;
        forever
        begin
            @(negedge clk);
            if (mem_ready)
            begin
                mem_ready  = 1'b0;    // done on the last edge
                delay_left = -1;
            end
            else if (!proc_reset && (mem_req.read || mem_req.write))
            begin
                if (delay_left < 0)
                    delay_left = int'($unsigned($random(seed)) % 4);
                if (delay_left == 0)
                begin
                    mem_ready = 1'b1;
                    if (mem_req.write)
                        mem_blocks[mem_req.addr] = mem_req.wdata;
                    else
                        mem_rdata = mem_block(mem_req.addr);
                end
                else
                    delay_left--;
            end
        end
    end

    initial
    begin
        #(WATCH_NS);
        $display("watchdog expired after %0d ns with the tests still running", WATCH_NS);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        cache_geom_pkg::proc_addr_t a;
        logic [31:0]                d;
        proc_req = '0;
        for (int i = 0; i < cache_geom_pkg::NUM_LINES; i++)
        begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        @(negedge proc_reset);
        #5;
        check_bit("proc_stall", proc_stall, 1'b0);
        check_bit("mem_req.read", mem_req.read, 1'b0);
        check_bit("mem_req.write", mem_req.write, 1'b0);
        do_read(make_addr(25'h12, 3'd1, 2'd0));    // cold cache
        end_test("reset");

        do_read(make_addr(25'h40, 3'd2, 2'd1));
        do_read(make_addr(25'h40, 3'd2, 2'd3));
        end_test("read miss then hit");

        do_write(make_addr(25'h40, 3'd2, 2'd2), 32'hcafe_0001);
        do_read(make_addr(25'h40, 3'd2, 2'd2));
        end_test("write hit");

        do_write(make_addr(25'h77, 3'd5, 2'd0), 32'h1234_5678);
        do_read(make_addr(25'h77, 3'd5, 2'd1));
        do_read(make_addr(25'h77, 3'd5, 2'd0));
        end_test("write miss");

        // same index and two tags so every access evicts the other
        for (int i = 0; i < 3; i++)
        begin
            do_read(make_addr(25'h05, 3'd6, 2'd0));
            do_read(make_addr(25'h09, 3'd6, 2'd3));
        end
        end_test("conflict");

        for (int i = 0; i < RAND_OPS; i++)
        begin
            a = make_addr(25'($unsigned($random(seed)) % 4), 3'($unsigned($random(seed)) % 8),
                          2'($unsigned($random(seed)) % 4));
            if ($unsigned($random(seed)) % 10 < 4)
            begin
                d = $random(seed);
                do_write(a, d);
            end
            else
                do_read(a);
        end
        end_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* vlog.f */
source/cache_geom_pkg.sv
source/cache_bus_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_controller.sv
source/cache_top.sv
testbench/tb_clock_gen.sv
testbench/cache_asserts.sv
testbench/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -f vlog.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
